/* design/ib_cfg_regs.sv */
/*
 * Issue buffer configuration block
 * AXI4-Lite slave holding the per-class halt mask, issuing one-cycle
 * flush pulses and reporting the three queue occupancies
 */
`timescale 1ns/1ps
`include "ib_dispatch_consts.svh"

module ib_cfg_regs (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  logic [`IB_CNT_W-1:0]        alu_count_i,
    input  logic [`IB_CNT_W-1:0]        br_count_i,
    input  logic [`IB_CNT_W-1:0]        mem_count_i,
    output logic [2:0]                  halt_o,
    output logic [2:0]                  flush_o,
    input  logic [`IB_AXI_ADDR_W-1:0]   s_axi_awaddr_i,
    input  logic                        s_axi_awvalid_i,
    output logic                        s_axi_awready_o,
    input  logic [`IB_AXI_DATA_W-1:0]   s_axi_wdata_i,
    input  logic [`IB_AXI_DATA_W/8-1:0] s_axi_wstrb_i,
    input  logic                        s_axi_wvalid_i,
    output logic                        s_axi_wready_o,
    output logic [1:0]                  s_axi_bresp_o,
    output logic                        s_axi_bvalid_o,
    input  logic                        s_axi_bready_i,
    input  logic [`IB_AXI_ADDR_W-1:0]   s_axi_araddr_i,
    input  logic                        s_axi_arvalid_i,
    output logic                        s_axi_arready_o,
    output logic [`IB_AXI_DATA_W-1:0]   s_axi_rdata_o,
    output logic [1:0]                  s_axi_rresp_o,
    output logic                        s_axi_rvalid_o,
    input  logic                        s_axi_rready_i
);

    localparam int         DATA_W      = `IB_AXI_DATA_W;
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    logic              wr_fire;
    logic              rd_fire;
    logic [2:0]        halt_q;
    logic [2:0]        flush_q;
    logic              bvalid_q;
    logic [1:0]        bresp_q;
    logic              rvalid_q;
    logic [1:0]        rresp_q;
    logic [DATA_W-1:0] rdata_q;
    logic [DATA_W-1:0] status_word;
    logic [DATA_W-1:0] rd_word;
    logic              rd_err;

    // ============================================================
    // Write channel
    // ============================================================
    // AW and W taken together, one outstanding response
    assign s_axi_awready_o = s_axi_wvalid_i && !bvalid_q;
    assign s_axi_wready_o  = s_axi_awvalid_i && !bvalid_q;
    assign wr_fire         = s_axi_awvalid_i && s_axi_wvalid_i && !bvalid_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            halt_q   <= '0;
            flush_q  <= '0;
            bvalid_q <= 1'b0;
            bresp_q  <= RESP_OKAY;
        end else begin
            // Flush bits last one cycle
            flush_q <= '0;
            if (wr_fire) begin
                bvalid_q <= 1'b1;
                bresp_q  <= RESP_OKAY;
                case (s_axi_awaddr_i)
                    `IB_REG_CTRL:
                        if (s_axi_wstrb_i[0]) halt_q <= s_axi_wdata_i[2:0];
                    `IB_REG_FLUSH:
                        if (s_axi_wstrb_i[0]) flush_q <= s_axi_wdata_i[2:0];
                    // Status is read only, write ignored
                    `IB_REG_STATUS: ;
                    default: bresp_q <= RESP_SLVERR;
                endcase
            end else if (bvalid_q && s_axi_bready_i) begin
                bvalid_q <= 1'b0;
            end
        end
    end

    assign s_axi_bvalid_o = bvalid_q;
    assign s_axi_bresp_o  = bresp_q;
    assign halt_o         = halt_q;
    assign flush_o        = flush_q;

    // ============================================================
    // Read channel
    // ============================================================
    // Occupancies on byte lanes 0, 1 and 2
    always_comb begin
        status_word                       = '0;
        status_word[0  +: `IB_CNT_W]      = alu_count_i;
        status_word[8  +: `IB_CNT_W]      = br_count_i;
        status_word[16 +: `IB_CNT_W]      = mem_count_i;
    end

    always_comb begin
        rd_err  = 1'b0;
        case (s_axi_araddr_i)
            `IB_REG_CTRL:   rd_word = DATA_W'(halt_q);
            `IB_REG_FLUSH:  rd_word = '0;
            `IB_REG_STATUS: rd_word = status_word;
            default: begin
                rd_word = '0;
                rd_err  = 1'b1;
            end
        endcase
    end

    assign s_axi_arready_o = !rvalid_q;
    assign rd_fire         = s_axi_arvalid_i && !rvalid_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rvalid_q <= 1'b0;
            rresp_q  <= RESP_OKAY;
        end else if (rd_fire) begin
            rvalid_q <= 1'b1;
            rresp_q  <= rd_err ? RESP_SLVERR : RESP_OKAY;
        end else if (s_axi_rready_i) begin
            rvalid_q <= 1'b0;
        end
    end

    // Data captured at AR acceptance
    always_ff @(posedge clk_i) begin
        if (rd_fire)
            rdata_q <= rd_word;
    end

    assign s_axi_rvalid_o = rvalid_q;
    assign s_axi_rresp_o  = rresp_q;
    assign s_axi_rdata_o  = rdata_q;

    // Responses stay up until the master takes them
    a_bvalid_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        s_axi_bvalid_o && !s_axi_bready_i |=> s_axi_bvalid_o);
    a_rvalid_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        s_axi_rvalid_o && !s_axi_rready_i |=> s_axi_rvalid_o && $stable(s_axi_rdata_o));

endmodule

/* design/ib_dispatch_consts.svh */
/*
 * Issue buffer dispatch constants
 * Lane count, queue sizing, instruction field widths and the
 * AXI4-Lite register map of the configuration block
 */
`ifndef IB_DISPATCH_CONSTS_SVH
`define IB_DISPATCH_CONSTS_SVH

// Renamed instructions offered per cycle
`define IS_NUM          4
// Entries per class queue, power of two only
`define IB_QUEUE_DEPTH  8
// Occupancy count, must hold IB_QUEUE_DEPTH itself
`define IB_CNT_W        4

`define XLEN            32
`define ROB_TAG_W       6

// ============================================================
// AXI4-Lite configuration port
// ============================================================
`define IB_AXI_ADDR_W   8
`define IB_AXI_DATA_W   32
`define IB_REG_CTRL     8'h00
`define IB_REG_FLUSH    8'h04
`define IB_REG_STATUS   8'h08

`endif

/* design/ib_dispatch_top.sv */
/*
 * Issue buffer dispatch top
 * Routes each dispatch group to the ALU, branch and memory queues
 * and hangs the AXI4-Lite configuration block beside them
 */
`timescale 1ns/1ps
`include "ib_dispatch_consts.svh"

module ib_dispatch_top (
    input  logic                             clk_i,
    input  logic                             rst_n_i,
    input  logic [`IS_NUM-1:0]               rs_valid_i,
    input  ib_pkg::is_inst_t [`IS_NUM-1:0]   rs_inst_i,
    output logic                             rs_ready_o,
    output logic                             alu_valid_o,
    output ib_pkg::is_inst_t                 alu_inst_o,
    input  logic                             alu_ready_i,
    output logic                             br_valid_o,
    output ib_pkg::is_inst_t                 br_inst_o,
    input  logic                             br_ready_i,
    output logic                             mem_valid_o,
    output ib_pkg::is_inst_t                 mem_inst_o,
    input  logic                             mem_ready_i,
    input  logic [`IB_AXI_ADDR_W-1:0]        s_axi_awaddr_i,
    input  logic                             s_axi_awvalid_i,
    output logic                             s_axi_awready_o,
    input  logic [`IB_AXI_DATA_W-1:0]        s_axi_wdata_i,
    input  logic [`IB_AXI_DATA_W/8-1:0]      s_axi_wstrb_i,
    input  logic                             s_axi_wvalid_i,
    output logic                             s_axi_wready_o,
    output logic [1:0]                       s_axi_bresp_o,
    output logic                             s_axi_bvalid_o,
    input  logic                             s_axi_bready_i,
    input  logic [`IB_AXI_ADDR_W-1:0]        s_axi_araddr_i,
    input  logic                             s_axi_arvalid_i,
    output logic                             s_axi_arready_o,
    output logic [`IB_AXI_DATA_W-1:0]        s_axi_rdata_o,
    output logic [1:0]                       s_axi_rresp_o,
    output logic                             s_axi_rvalid_o,
    input  logic                             s_axi_rready_i
);

    // One router and queue per class, indexed by fu_class_e
    localparam int FU_NUM = 3;

    logic [FU_NUM-1:0]                           route_ready;
    logic [FU_NUM-1:0][`IS_NUM-1:0]              slot_valid;
    logic [FU_NUM-1:0][`IS_NUM-1:0]              slot_ready;
    ib_pkg::is_inst_t [FU_NUM-1:0][`IS_NUM-1:0]  slot_data;
    logic [FU_NUM-1:0]                           halt;
    logic [FU_NUM-1:0]                           flush;
    logic [FU_NUM-1:0]                           pop_valid;
    logic [FU_NUM-1:0]                           pop_ready;
    ib_pkg::is_inst_t [FU_NUM-1:0]               pop_data;
    logic [FU_NUM-1:0][`IB_CNT_W-1:0]            count;

    // Whole group waits unless every class has room for a full group
    assign rs_ready_o = &route_ready;

    // ============================================================
    // Per-class router and queue
    // ============================================================
    for (genvar c = 0; c < FU_NUM; c++) begin : g_fu
        ib_push_in_router #(
            .C_IN_NUM  (`IS_NUM),
            .C_OUT_NUM (`IS_NUM),
            .C_FU_SEL  (ib_pkg::fu_class_e'(c))
        ) u_router (
            .rs_valid_i (rs_valid_i),
            .rs_inst_i  (rs_inst_i),
            .accept_i   (rs_ready_o),
            .ready_o    (route_ready[c]),
            .m_valid_o  (slot_valid[c]),
            .m_ready_i  (slot_ready[c]),
            .m_data_o   (slot_data[c])
        );

        ib_fu_queue #(
            .C_PUSH_NUM (`IS_NUM),
            .C_DEPTH    (`IB_QUEUE_DEPTH)
        ) u_queue (
            .clk_i        (clk_i),
            .rst_n_i      (rst_n_i),
            .push_valid_i (slot_valid[c]),
            .push_data_i  (slot_data[c]),
            .push_ready_o (slot_ready[c]),
            .halt_i       (halt[c]),
            .flush_i      (flush[c]),
            .pop_valid_o  (pop_valid[c]),
            .pop_data_o   (pop_data[c]),
            .pop_ready_i  (pop_ready[c]),
            .count_o      (count[c])
        );
    end

    // Issue ports
    assign alu_valid_o = pop_valid[ib_pkg::FU_ALU];
    assign alu_inst_o  = pop_data[ib_pkg::FU_ALU];
    assign br_valid_o  = pop_valid[ib_pkg::FU_BR];
    assign br_inst_o   = pop_data[ib_pkg::FU_BR];
    assign mem_valid_o = pop_valid[ib_pkg::FU_MEM];
    assign mem_inst_o  = pop_data[ib_pkg::FU_MEM];
    assign pop_ready   = {mem_ready_i, br_ready_i, alu_ready_i};

    // ============================================================
    // Configuration
    // ============================================================
    ib_cfg_regs u_cfg (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .alu_count_i     (count[ib_pkg::FU_ALU]),
        .br_count_i      (count[ib_pkg::FU_BR]),
        .mem_count_i     (count[ib_pkg::FU_MEM]),
        .halt_o          (halt),
        .flush_o         (flush),
        .s_axi_awaddr_i  (s_axi_awaddr_i),
        .s_axi_awvalid_i (s_axi_awvalid_i),
        .s_axi_awready_o (s_axi_awready_o),
        .s_axi_wdata_i   (s_axi_wdata_i),
        .s_axi_wstrb_i   (s_axi_wstrb_i),
        .s_axi_wvalid_i  (s_axi_wvalid_i),
        .s_axi_wready_o  (s_axi_wready_o),
        .s_axi_bresp_o   (s_axi_bresp_o),
        .s_axi_bvalid_o  (s_axi_bvalid_o),
        .s_axi_bready_i  (s_axi_bready_i),
        .s_axi_araddr_i  (s_axi_araddr_i),
        .s_axi_arvalid_i (s_axi_arvalid_i),
        .s_axi_arready_o (s_axi_arready_o),
        .s_axi_rdata_o   (s_axi_rdata_o),
        .s_axi_rresp_o   (s_axi_rresp_o),
        .s_axi_rvalid_o  (s_axi_rvalid_o),
        .s_axi_rready_i  (s_axi_rready_i)
    );

endmodule

/* design/ib_fu_queue.sv */
/*
 * Functional-unit class queue
 * Circular FIFO taking up to C_PUSH_NUM pushes and giving one pop
 * per cycle, with halt on the pop side and a full flush
 */
`timescale 1ns/1ps
`include "ib_dispatch_consts.svh"

module ib_fu_queue #(
    parameter int C_PUSH_NUM = `IS_NUM,
    parameter int C_DEPTH    = `IB_QUEUE_DEPTH
) (
    input  logic                                clk_i,
    input  logic                                rst_n_i,
    input  logic [C_PUSH_NUM-1:0]               push_valid_i,
    input  ib_pkg::is_inst_t [C_PUSH_NUM-1:0]   push_data_i,
    output logic [C_PUSH_NUM-1:0]               push_ready_o,
    input  logic                                halt_i,
    input  logic                                flush_i,
    output logic                                pop_valid_o,
    output ib_pkg::is_inst_t                    pop_data_o,
    input  logic                                pop_ready_i,
    output logic [`IB_CNT_W-1:0]                count_o
);

    localparam int PTR_W = $clog2(C_DEPTH);
    localparam int CNT_W = `IB_CNT_W;

    // Payload storage
    ib_pkg::is_inst_t mem [C_DEPTH];

    logic [PTR_W-1:0] head_q;
    logic [PTR_W-1:0] tail_q;
    logic [CNT_W-1:0] count_q;
    logic [CNT_W-1:0] free_cnt;
    logic [CNT_W-1:0] push_num;
    logic             pop_fire;

    // ============================================================
    // Push side
    // ============================================================
    // Slots come in as a run from 0, so a plain popcount
    always_comb begin
        push_num = '0;
        for (int k = 0; k < C_PUSH_NUM; k++) begin
            push_num = push_num + CNT_W'(push_valid_i[k]);
        end
    end

    assign free_cnt = CNT_W'(C_DEPTH) - count_q;

    // Slot k ready when more than k entries are free
    always_comb begin
        for (int k = 0; k < C_PUSH_NUM; k++) begin
            push_ready_o[k] = (free_cnt > CNT_W'(k));
        end
    end

    // Flush discards a push in the same cycle
    always_ff @(posedge clk_i) begin
        if (!flush_i) begin
            for (int k = 0; k < C_PUSH_NUM; k++) begin
                if (push_valid_i[k])
                    mem[PTR_W'(tail_q + k)] <= push_data_i[k];
            end
        end
    end

    // ============================================================
    // Pop side
    // ============================================================
    assign pop_valid_o = (count_q != '0) && !halt_i;
    assign pop_data_o  = mem[head_q];
    assign pop_fire    = pop_valid_o && pop_ready_i;
    assign count_o     = count_q;

    // Pointers wrap on their own width, depth is a power of two
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else if (flush_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            tail_q  <= tail_q + PTR_W'(push_num);
            head_q  <= head_q + PTR_W'(pop_fire);
            count_q <= count_q + push_num - CNT_W'(pop_fire);
        end
    end

    // Router and top must only offer a group that fits
    a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (push_valid_i & ~push_ready_o) == '0);
    // Pointers and count agree that the queue holds something
    a_pop_nonempty: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        pop_fire |-> (head_q != tail_q) || (count_q == CNT_W'(C_DEPTH)));
    a_count_bound: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        count_q <= CNT_W'(C_DEPTH));

endmodule

/* design/ib_pkg.sv */
/*
 * Issue buffer package
 * Functional-unit class encoding and the packed renamed instruction
 * carried from the dispatch lanes to the issue ports
 */
`include "ib_dispatch_consts.svh"

package ib_pkg;

    // Class of the unit that executes an instruction
    // Code 3 is reserved and matches no router
    typedef enum logic [1:0] {
        FU_ALU = 2'd0,
        FU_BR  = 2'd1,
        FU_MEM = 2'd2
    } fu_class_e;

    // Renamed instruction as it sits in a class queue
    // Class field first, so routers can pick it off the top bits
    typedef struct packed {
        fu_class_e              fu_class;
        logic [`ROB_TAG_W-1:0]  rob_tag;
        logic [`XLEN-1:0]       pc;
        logic [`XLEN-1:0]       imm;
        logic [7:0]             opcode;
        // Physical destination
        logic [5:0]             dst_reg;
        // Branch flavour, both low for non-branches
        logic                   cond_br;
        logic                   uncond_br;
    } is_inst_t;

endpackage

/* design/ib_push_in_router.sv */
/*
 * Push-in router
 * Picks the lanes of one functional-unit class out of a dispatch group
 * and packs them toward slot 0 in lane order for the class queue
 */
`timescale 1ns/1ps
`include "ib_dispatch_consts.svh"

module ib_push_in_router #(
    parameter int                C_IN_NUM  = `IS_NUM,
    parameter int                C_OUT_NUM = `IS_NUM,
    parameter ib_pkg::fu_class_e C_FU_SEL  = ib_pkg::FU_ALU
) (
    input  logic [C_IN_NUM-1:0]                     rs_valid_i,
    input  ib_pkg::is_inst_t [C_IN_NUM-1:0]         rs_inst_i,
    input  logic                                    accept_i,
    output logic                                    ready_o,
    output logic [C_OUT_NUM-1:0]                    m_valid_o,
    input  logic [C_OUT_NUM-1:0]                    m_ready_i,
    output ib_pkg::is_inst_t [C_OUT_NUM-1:0]        m_data_o
);

    // Lanes that hold an instruction of this class
    logic [C_IN_NUM-1:0] sel_lane;

    // ============================================================
    // Lane selection
    // ============================================================
    always_comb begin
        for (int i = 0; i < C_IN_NUM; i++) begin
            sel_lane[i] = rs_valid_i[i] && (rs_inst_i[i].fu_class == C_FU_SEL);
        end
    end

    // Group can go only if the queue takes a full group
    assign ready_o = &m_ready_i;

    // ============================================================
    // Compaction
    // ============================================================
    // k-th selected lane lands in slot k
    // Valids held back until the whole group is accepted
    always_comb begin
        int slot;
        slot      = 0;
        m_valid_o = '0;
        m_data_o  = '0;
        for (int i = 0; i < C_IN_NUM; i++) begin
            if (sel_lane[i] && (slot < C_OUT_NUM)) begin
                m_data_o[slot]  = rs_inst_i[i];
                m_valid_o[slot] = accept_i;
                slot++;
            end
        end
    end

    // Queue writes from slot 0 upward without gaps
    // A valid set of the form 0..01..1 has v & (v + 1) == 0
    always_comb begin
        a_slot_run: assert final ((m_valid_o & (m_valid_o + C_OUT_NUM'(1))) == '0)
            else $error("router %0d: non-contiguous slots %b", C_FU_SEL, m_valid_o);
    end

endmodule

/* dv/tb_ib_model.svh */
/*
 * Issue buffer reference model
 * One queue per class in lane order, plus the typed compare tasks
 */
`ifndef TB_IB_MODEL_SVH
`define TB_IB_MODEL_SVH

// Expected contents of the ALU, branch and memory queues
ib_pkg::is_inst_t model_q [3][$];
int err_cnt   = 0;
int check_cnt = 0;

function automatic string port_name(input int c);
    case (c)
        0:       return "alu";
        1:       return "br";
        default: return "mem";
    endcase
endfunction

task automatic report_error(input string msg);
    err_cnt++;
    $display("ERROR: %s", msg);
endtask

task automatic check_inst(input string name, input ib_pkg::is_inst_t got,
                          input ib_pkg::is_inst_t exp);
    check_cnt++;
    if (got !== exp) begin
        err_cnt++;
        $display("FAIL %s: got %h expected %h", name, got, exp);
    end
endtask

task automatic check_word(input string name, input logic [`IB_AXI_DATA_W-1:0] got,
                          input logic [`IB_AXI_DATA_W-1:0] exp);
    check_cnt++;
    if (got !== exp) begin
        err_cnt++;
        $display("FAIL %s: got %h expected %h", name, got, exp);
    end
endtask

function automatic int model_free(input int c);
    return `IB_QUEUE_DEPTH - model_q[c].size();
endfunction

// Accepted group, reserved class 3 goes nowhere
task automatic model_accept(input logic [`IS_NUM-1:0] valid,
                            input ib_pkg::is_inst_t [`IS_NUM-1:0] insts);
    for (int i = 0; i < `IS_NUM; i++) begin
        if (valid[i] && int'(insts[i].fu_class) < 3)
            model_q[int'(insts[i].fu_class)].push_back(insts[i]);
    end
endtask

task automatic model_pop(input int c, input ib_pkg::is_inst_t got);
    if (model_q[c].size() == 0)
        report_error($sformatf("%s port issued with nothing queued", port_name(c)));
    else
        check_inst({port_name(c), "_inst_o"}, got, model_q[c].pop_front());
endtask

// STATUS layout: one count per byte lane
function automatic logic [`IB_AXI_DATA_W-1:0] model_status();
    logic [`IB_AXI_DATA_W-1:0] w;
    w = '0;
    for (int c = 0; c < 3; c++)
        w[8*c +: `IB_CNT_W] = `IB_CNT_W'(model_q[c].size());
    return w;
endfunction

`endif

/* dv/tb_ib_dispatch.sv */
/*
 * Issue buffer dispatch testbench
 * Random dispatch groups against a queue model, with back-pressure,
 * halt, flush, status and bad-address register checks
 */
`timescale 1ns/1ps
`include "ib_dispatch_consts.svh"

module tb_ib_dispatch;

    localparam int ROUTE_GROUPS = 400;
    localparam int BP_GROUPS    = 300;
    // Reset, register tests and drain plus per-group budgets
    localparam int PLANNED      = 10 + 400 + ROUTE_GROUPS * 4 + BP_GROUPS * 12;
    localparam int CYCLE_LIMIT  = 2 * PLANNED;

    logic                            clk;
    logic                            rst_n;
    logic [`IS_NUM-1:0]              rs_valid;
    ib_pkg::is_inst_t [`IS_NUM-1:0]  rs_inst;
    logic                            rs_ready;
    logic [2:0]                      port_valid;
    ib_pkg::is_inst_t                port_inst [3];
    logic [2:0]                      issue_ready;
    logic [`IB_AXI_ADDR_W-1:0]       awaddr;
    logic [`IB_AXI_ADDR_W-1:0]       araddr;
    logic [`IB_AXI_DATA_W-1:0]       wdata;
    logic [`IB_AXI_DATA_W-1:0]       rdata;
    logic [3:0]                      wstrb;
    logic [1:0]                      bresp;
    logic [1:0]                      rresp;
    logic                            awvalid;
    logic                            awready;
    logic                            wvalid;
    logic                            wready;
    logic                            bvalid;
    logic                            bready;
    logic                            arvalid;
    logic                            arready;
    logic                            rvalid;
    logic                            rready;

    logic [2:0] halt_mask  = '0;
    logic [2:0] head_due   = '0;
    bit         bp_done    = 0;
    int         cycle_cnt  = 0;
    int         test_cnt   = 0;
    int         test_start = 0;

    `include "tb_ib_model.svh"

    ib_dispatch_top dut (
        .clk_i (clk), .rst_n_i (rst_n),
        .rs_valid_i (rs_valid), .rs_inst_i (rs_inst), .rs_ready_o (rs_ready),
        .alu_valid_o (port_valid[0]), .alu_inst_o (port_inst[0]), .alu_ready_i (issue_ready[0]),
        .br_valid_o  (port_valid[1]), .br_inst_o  (port_inst[1]), .br_ready_i  (issue_ready[1]),
        .mem_valid_o (port_valid[2]), .mem_inst_o (port_inst[2]), .mem_ready_i (issue_ready[2]),
        .s_axi_awaddr_i (awaddr), .s_axi_awvalid_i (awvalid), .s_axi_awready_o (awready),
        .s_axi_wdata_i (wdata), .s_axi_wstrb_i (wstrb), .s_axi_wvalid_i (wvalid),
        .s_axi_wready_o (wready), .s_axi_bresp_o (bresp), .s_axi_bvalid_o (bvalid),
        .s_axi_bready_i (bready), .s_axi_araddr_i (araddr), .s_axi_arvalid_i (arvalid),
        .s_axi_arready_o (arready), .s_axi_rdata_o (rdata), .s_axi_rresp_o (rresp),
        .s_axi_rvalid_o (rvalid), .s_axi_rready_i (rready)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Hard stop on a hung handshake
    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("Timeout: run still going after %0d cycles", CYCLE_LIMIT);
            $display("Result: FAILED");
            $finish;
        end
    end

    // ============================================================
    // Monitor sampled at the rising edge
    // ============================================================
    always @(posedge clk) begin : monitor
        logic exp_ready;
        if (rst_n) begin
            exp_ready = 1'b1;
            for (int c = 0; c < 3; c++)
                exp_ready &= (model_free(c) >= `IS_NUM);
            check_word("rs_ready_o", 32'(rs_ready), 32'(exp_ready));
            for (int c = 0; c < 3; c++) begin
                if (head_due[c] && !port_valid[c])
                    report_error($sformatf("%s head not valid a cycle after push",
                                           port_name(c)));
                // Empty and running so a push shows up next cycle
                head_due[c] = (model_q[c].size() == 0) && !halt_mask[c];
                if (port_valid[c] && issue_ready[c])
                    model_pop(c, port_inst[c]);
            end
            if (rs_ready)
                model_accept(rs_valid, rs_inst);
            for (int c = 0; c < 3; c++)
                head_due[c] = head_due[c] && (model_q[c].size() != 0);
        end
    end

    // ============================================================
    // Stimulus tasks
    // ============================================================
    function automatic ib_pkg::is_inst_t rand_inst();
        ib_pkg::is_inst_t inst;
        inst.fu_class  = ib_pkg::fu_class_e'($urandom_range(3));
        inst.rob_tag   = `ROB_TAG_W'($urandom);
        inst.pc        = $urandom;
        inst.imm       = $urandom;
        inst.opcode    = 8'($urandom);
        inst.dst_reg   = 6'($urandom);
        inst.cond_br   = 1'($urandom);
        inst.uncond_br = 1'($urandom);
        return inst;
    endfunction

    // Group held until accepted
    // Lanes cycle through the classes if asked
    task automatic send_group(input logic [`IS_NUM-1:0] mask, input bit every_class);
        @(negedge clk);
        rs_valid = mask;
        for (int i = 0; i < `IS_NUM; i++) begin
            rs_inst[i] = rand_inst();
            if (every_class)
                rs_inst[i].fu_class = ib_pkg::fu_class_e'(i % 3);
        end
        do @(posedge clk); while (!rs_ready);
    endtask

    task automatic idle_lanes();
        @(negedge clk);
        rs_valid = '0;
    endtask

    task automatic set_readies(input logic [2:0] r);
        @(negedge clk);
        issue_ready = r;
    endtask

    // Random stalls with a long one now and then
    task automatic toggle_readies();
        int hold [3];
        for (int c = 0; c < 3; c++)
            hold[c] = 0;
        while (!bp_done) begin
            @(negedge clk);
            for (int c = 0; c < 3; c++) begin
                if (hold[c] == 0) begin
                    issue_ready[c] = 1'($urandom_range(1));
                    if (!issue_ready[c] && $urandom_range(7) == 0)
                        hold[c] = $urandom_range(40, 20);
                    else
                        hold[c] = $urandom_range(6, 1);
                end else begin
                    hold[c]--;
                end
            end
        end
    endtask

    task automatic drain_queues();
        set_readies(3'b111);
        while (model_q[0].size() + model_q[1].size() + model_q[2].size() != 0)
            @(posedge clk);
        @(negedge clk);
        for (int c = 0; c < 3; c++)
            check_word({port_name(c), "_valid_o"}, 32'(port_valid[c]), 32'h0);
    endtask

    task automatic axi_write(input logic [7:0] addr, input logic [31:0] data,
                             output logic [1:0] resp);
        @(negedge clk);
        awaddr  = addr;
        wdata   = data;
        wstrb   = 4'hf;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        // Address and data taken in the same cycle
        do @(posedge clk); while (!(awready && wready));
        @(negedge clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        bready  = 1'b1;
        do @(posedge clk); while (!bvalid);
        resp = bresp;
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic axi_read(input logic [7:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        @(negedge clk);
        araddr  = addr;
        arvalid = 1'b1;
        do @(posedge clk); while (!arready);
        @(negedge clk);
        arvalid = 1'b0;
        rready  = 1'b1;
        do @(posedge clk); while (!rvalid);
        data = rdata;
        resp = rresp;
        @(negedge clk);
        rready = 1'b0;
    endtask

    task automatic expect_reg(input logic [7:0] addr, input logic [31:0] exp,
                              input string name);
        logic [31:0] data;
        logic [1:0]  resp;
        axi_read(addr, data, resp);
        check_word(name, data, exp);
        check_word({name, " rresp"}, 32'(resp), 32'h0);
    endtask

    task automatic end_test(input string name);
        $display("test %s %s, %0d errors", name,
                 (err_cnt == test_start) ? "clean" : "with errors", err_cnt - test_start);
        test_cnt++;
        test_start = err_cnt;
    endtask

    // ============================================================
    // Test sequence
    // ============================================================
    initial begin
        logic [2:0]  mask;
        logic [1:0]  resp;
        logic [31:0] data;
        void'($urandom(62));
        rst_n = 1'b0;
        rs_valid = '0;
        rs_inst = '0;
        issue_ready = '0;
        {awaddr, araddr, wdata, wstrb} = '0;
        {awvalid, wvalid, bready, arvalid, rready} = '0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        @(negedge clk);
        for (int c = 0; c < 3; c++)
            check_word({port_name(c), "_valid_o"}, 32'(port_valid[c]), 32'h0);
        check_word("rs_ready_o", 32'(rs_ready), 32'h1);
        expect_reg(`IB_REG_STATUS, 32'h0, "STATUS");
        expect_reg(`IB_REG_CTRL, 32'h0, "CTRL");
        end_test("reset");

        set_readies(3'b111);
        repeat (ROUTE_GROUPS) send_group(4'($urandom), 1'b0);
        idle_lanes();
        drain_queues();
        end_test("routing");

        fork
            begin
                repeat (BP_GROUPS) send_group(4'($urandom), 1'b0);
                idle_lanes();
                bp_done = 1;
            end
            toggle_readies();
        join
        drain_queues();
        end_test("backpress");

        // Fill every class while stalled, then halt some
        set_readies(3'b000);
        send_group(4'hf, 1'b1);
        send_group(4'($urandom), 1'b0);
        idle_lanes();
        mask = 3'($urandom_range(7, 1));
        axi_write(`IB_REG_CTRL, 32'(mask), resp);
        check_word("bresp", 32'(resp), 32'h0);
        halt_mask = mask;
        set_readies(3'b111);
        repeat (20) begin
            @(negedge clk);
            for (int c = 0; c < 3; c++)
                if (halt_mask[c] && port_valid[c])
                    report_error($sformatf("%s port valid while halted", port_name(c)));
        end
        for (int c = 0; c < 3; c++)
            if ((model_q[c].size() != 0) != halt_mask[c])
                report_error($sformatf("%s queue fill wrong for halt state", port_name(c)));
        expect_reg(`IB_REG_CTRL, 32'(mask), "CTRL");
        axi_write(`IB_REG_CTRL, 32'h0, resp);
        halt_mask = '0;
        drain_queues();
        end_test("halt");

        set_readies(3'b000);
        send_group(4'hf, 1'b1);
        send_group(4'($urandom), 1'b0);
        idle_lanes();
        expect_reg(`IB_REG_STATUS, model_status(), "STATUS");
        mask = 3'($urandom_range(7, 1));
        axi_write(`IB_REG_FLUSH, 32'(mask), resp);
        check_word("bresp", 32'(resp), 32'h0);
        for (int c = 0; c < 3; c++)
            if (mask[c])
                model_q[c].delete();
        @(negedge clk);
        for (int c = 0; c < 3; c++)
            check_word({port_name(c), "_valid_o"}, 32'(port_valid[c]),
                       32'(model_q[c].size() != 0));
        expect_reg(`IB_REG_STATUS, model_status(), "STATUS");
        expect_reg(`IB_REG_FLUSH, 32'h0, "FLUSH");
        drain_queues();
        end_test("flush");

        // Unmapped offset with every queue holding entries
        set_readies(3'b000);
        send_group(4'hf, 1'b1);
        idle_lanes();
        axi_write(8'h10, 32'hffff_ffff, resp);
        check_word("bresp", 32'(resp), 32'h2);
        axi_read(8'h10, data, resp);
        check_word("rresp", 32'(resp), 32'h2);
        expect_reg(`IB_REG_CTRL, 32'h0, "CTRL");
        expect_reg(`IB_REG_STATUS, model_status(), "STATUS");
        drain_queues();
        end_test("badaddr");

        $display("tests %0d, checks %0d, errors %0d", test_cnt, check_cnt, err_cnt);
        if (err_cnt == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

/* ib_dispatch.f */
+incdir+design
+incdir+dv
design/ib_pkg.sv
design/ib_push_in_router.sv
design/ib_fu_queue.sv
design/ib_cfg_regs.sv
design/ib_dispatch_top.sv
dv/tb_ib_dispatch.sv
